/* Bender.yml */
package:
  name: rv32_decode

sources:
  - hw/rv32_types_pkg.sv
  - hw/rv32_decoder.sv
  - hw/rv32_hazard_unit.sv
  - hw/rv32_decode_stage.sv
  - hw/rv32_regfile.sv
  - hw/rv32_decode_top.sv
  - target: test
    files:
      - verif/tb_decode_props.sv
      - verif/tb_decode_top.sv

/* hw/rv32_decode_stage.sv */
// ******************************************************************
// Decode stage of the five-stage pipeline. Decodes, reads operands,
// detects hazards and registers the decode/execute buffer.
// ******************************************************************
`timescale 1ns/1ps
`default_nettype none

module rv32_decode_stage #(
    parameter int REG_COUNT = 32
) (
    input  logic                                 clk,
    input  logic                                 resetn,
    input  logic                                 set_nop,
    input  logic                                 stop,
    input  rv32_types_pkg::rv32_word             set_nop_pc,
    input  rv32_types_pkg::fetch_decode_buffer_t fetch_decode_buff,
    input  rv32_types_pkg::rv_instr_t            instr,
    output logic [4:0]                           rs1_addr,
    output logic [4:0]                           rs2_addr,
    input  rv32_types_pkg::rv32_word [1:0]       reg_data,
    input  rv32_types_pkg::rv32_word             csr_data,
    input  rv32_types_pkg::exec_mem_buffer_t     exec_mem_buff,
    output rv32_types_pkg::decode_exec_buffer_t  decode_exec_buff,
    output logic                                 stall
);
    import rv32_types_pkg::*;

    rv_instr_t           internal_instr;
    logic [1:0]          use_rs;
    rv_control_t         dec_control;
    bypass_e [1:0]       bypass_rs;
    logic                hazard_stall;
    decode_exec_buffer_t next_data;

    // Fetch bubble
    assign internal_instr = fetch_decode_buff.generate_nop ? RV_NOP : instr;

    rv32_decoder #(
        .REG_COUNT(REG_COUNT)
    ) u_decoder (
        .instr  (internal_instr),
        .use_rs (use_rs),
        .control(dec_control)
    );

    rv32_hazard_unit u_hazard (
        .use_rs          (use_rs),
        .current_control (dec_control),
        .decode_exec_buff(decode_exec_buff),
        .exec_mem_buff   (exec_mem_buff),
        .stall           (hazard_stall),
        .bypass_rs       (bypass_rs)
    );

    assign rs1_addr = dec_control.rs1;
    assign rs2_addr = dec_control.rs2;
    assign stall = hazard_stall;

    always_comb begin
        next_data.pc = fetch_decode_buff.pc;
        next_data.instr = internal_instr;
        next_data.control = dec_control;
        next_data.control.bypass_rs = bypass_rs;
        next_data.reg_data[0] = reg_data[0];
        next_data.reg_data[1] = reg_data[1];
        // CSR read is done early, here in decode
        next_data.reg_data[2] = (dec_control.wb_result_src == WB_CSR) ? csr_data : '0;

        if (hazard_stall || set_nop) begin
            next_data.instr = RV_NOP;
            next_data.control = create_nop_ctrl();
            if (set_nop) begin
                next_data.pc = set_nop_pc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            decode_exec_buff.pc <= '0;
            decode_exec_buff.instr <= RV_NOP;
            decode_exec_buff.control <= create_nop_ctrl();
            decode_exec_buff.reg_data <= '0;
        end else if (!stop) begin
            decode_exec_buff <= next_data;
        end
    end

endmodule

`default_nettype wire

/* hw/rv32_decode_top.sv */
// ******************************************************************
// Standalone decode top: register file plus decode stage.
// Set REG_COUNT to 16 for an RV32E build.
// ******************************************************************
`timescale 1ns/1ps
`default_nettype none

module rv32_decode_top #(
    parameter int REG_COUNT = 32
) (
    input  logic                                 clk,
    input  logic                                 resetn,
    input  rv32_types_pkg::rv_instr_t            instr,
    input  rv32_types_pkg::fetch_decode_buffer_t fetch_decode_buff,
    input  logic                                 set_nop,
    input  rv32_types_pkg::rv32_word             set_nop_pc,
    input  logic                                 stop,
    input  rv32_types_pkg::rv32_word             csr_data,
    input  rv32_types_pkg::exec_mem_buffer_t     exec_mem_buff,
    input  logic                                 wb_en,
    input  logic [4:0]                           wb_addr,
    input  rv32_types_pkg::rv32_word             wb_data,
    output rv32_types_pkg::decode_exec_buffer_t  decode_exec_buff,
    output logic                                 stall
);
    import rv32_types_pkg::*;

    logic [4:0]     rs1_addr;
    logic [4:0]     rs2_addr;
    rv32_word [1:0] reg_data;

    rv32_regfile #(
        .REG_COUNT(REG_COUNT)
    ) u_regfile (
        .clk     (clk),
        .resetn  (resetn),
        .rs1_addr(rs1_addr),
        .rs2_addr(rs2_addr),
        .rs1_data(reg_data[0]),
        .rs2_data(reg_data[1]),
        .wb_en   (wb_en),
        .wb_addr (wb_addr),
        .wb_data (wb_data)
    );

    rv32_decode_stage #(
        .REG_COUNT(REG_COUNT)
    ) u_decode (
        .clk              (clk),
        .resetn           (resetn),
        .set_nop          (set_nop),
        .stop             (stop),
        .set_nop_pc       (set_nop_pc),
        .fetch_decode_buff(fetch_decode_buff),
        .instr            (instr),
        .rs1_addr         (rs1_addr),
        .rs2_addr         (rs2_addr),
        .reg_data         (reg_data),
        .csr_data         (csr_data),
        .exec_mem_buff    (exec_mem_buff),
        .decode_exec_buff (decode_exec_buff),
        .stall            (stall)
    );

endmodule

`default_nettype wire

/* hw/rv32_decoder.sv */
// ******************************************************************
// Combinational RV32I instruction decoder. Produces the control
// bundle and the source-register use flags for one instruction.
// ******************************************************************
`timescale 1ns/1ps
`default_nettype none

module rv32_decoder #(
    parameter int REG_COUNT = 32
) (
    input  rv32_types_pkg::rv_instr_t   instr,
    output logic [1:0]                  use_rs,
    output rv32_types_pkg::rv_control_t control
);
    import rv32_types_pkg::*;

    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_SYSTEM = 7'b1110011
    } opcode_e;

    opcode_e    opcode;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [2:0] funct3;
    logic       funct7_b5;
    rv32_word   imm_i;
    rv32_word   imm_s;
    rv32_word   imm_b;
    rv32_word   imm_u;
    rv32_word   imm_j;
    logic       unknown;
    logic       bad_reg;

    assign opcode    = opcode_e'(instr[6:0]);
    assign rd        = instr[11:7];
    assign funct3    = instr[14:12];
    assign rs1       = instr[19:15];
    assign rs2       = instr[24:20];
    assign funct7_b5 = instr[30];

    // Immediates for every format, sign extended from bit 31
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // SUB only exists in the register form, SRA in both
    function automatic alu_op_e alu_op_from(logic [2:0] f3, logic f7_b5, logic is_reg);
        case (f3)
            3'b000:  return (is_reg && f7_b5) ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return f7_b5 ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    always_comb begin
        control = create_nop_ctrl();
        use_rs = 2'b00;
        unknown = 1'b0;
        case (opcode)
            OP_LUI: begin
                control.alu_op = ALU_PASS_B;
                control.alu_src_imm = 1'b1;
                control.imm = imm_u;
                control.reg_write = 1'b1;
            end
            OP_AUIPC: begin
                control.alu_src_imm = 1'b1;
                control.imm = imm_u;
                control.reg_write = 1'b1;
            end
            OP_JAL: begin
                control.imm = imm_j;
                control.jump = 1'b1;
                control.reg_write = 1'b1;
                control.wb_result_src = WB_PC4;
            end
            OP_JALR: begin
                control.alu_src_imm = 1'b1;
                control.imm = imm_i;
                control.jump = 1'b1;
                control.reg_write = 1'b1;
                control.wb_result_src = WB_PC4;
                use_rs = 2'b01;
                unknown = (funct3 != 3'b000);
            end
            OP_BRANCH: begin
                control.imm = imm_b;
                control.branch = 1'b1;
                use_rs = 2'b11;
                // BEQ/BNE compare by subtraction, the rest by set-less-than
                case (funct3[2:1])
                    2'b00:   control.alu_op = ALU_SUB;
                    2'b10:   control.alu_op = ALU_SLT;
                    2'b11:   control.alu_op = ALU_SLTU;
                    default: unknown = 1'b1;
                endcase
            end
            OP_LOAD: begin
                control.alu_src_imm = 1'b1;
                control.imm = imm_i;
                control.mem_read = 1'b1;
                control.reg_write = 1'b1;
                control.wb_result_src = WB_MEM;
                use_rs = 2'b01;
            end
            OP_STORE: begin
                control.alu_src_imm = 1'b1;
                control.imm = imm_s;
                control.mem_write = 1'b1;
                use_rs = 2'b11;
            end
            OP_IMM: begin
                control.alu_op = alu_op_from(funct3, funct7_b5, 1'b0);
                control.alu_src_imm = 1'b1;
                control.imm = imm_i;
                control.reg_write = 1'b1;
                use_rs = 2'b01;
            end
            OP_REG: begin
                control.alu_op = alu_op_from(funct3, funct7_b5, 1'b1);
                control.reg_write = 1'b1;
                use_rs = 2'b11;
            end
            OP_SYSTEM: begin
                // CSR address rides in imm, the old value returns via slot 2
                control.imm = {20'b0, instr[31:20]};
                control.reg_write = 1'b1;
                control.wb_result_src = WB_CSR;
                use_rs = 2'b01;
                case (funct3)
                    3'b001:  control.alu_op = ALU_ADD;
                    3'b010:  control.alu_op = ALU_OR;
                    default: unknown = 1'b1;
                endcase
            end
            default: unknown = 1'b1;
        endcase

        // Unused register fields read as x0
        control.rd = control.reg_write ? rd : 5'd0;
        control.rs1 = use_rs[0] ? rs1 : 5'd0;
        control.rs2 = use_rs[1] ? rs2 : 5'd0;

        // RV32E has only 16 registers
        bad_reg = (control.reg_write && int'(rd) >= REG_COUNT)
            || (use_rs[0] && int'(rs1) >= REG_COUNT)
            || (use_rs[1] && int'(rs2) >= REG_COUNT);

        if (unknown || bad_reg) begin
            control = create_nop_ctrl();
            control.illegal = 1'b1;
            use_rs = 2'b00;
        end
    end

endmodule

`default_nettype wire

/* hw/rv32_hazard_unit.sv */
// ******************************************************************
// Data hazard unit of the decode stage. Flags load-use stalls and
// picks a bypass source for rs1 and rs2 from the later stages.
// ******************************************************************
`timescale 1ns/1ps
`default_nettype none

module rv32_hazard_unit (
    input  logic [1:0]                          use_rs,
    input  rv32_types_pkg::rv_control_t         current_control,
    input  rv32_types_pkg::decode_exec_buffer_t decode_exec_buff,
    input  rv32_types_pkg::exec_mem_buffer_t    exec_mem_buff,
    output logic                                stall,
    output rv32_types_pkg::bypass_e [1:0]       bypass_rs
);
    import rv32_types_pkg::*;

    logic [1:0][4:0] src;
    logic [1:0]      active;
    logic [1:0]      exec_hit;
    logic [1:0]      mem_hit;
    logic [1:0]      load_use;

    assign src[0] = current_control.rs1;
    assign src[1] = current_control.rs2;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            // x0 is constant and never forwarded
            active[i] = use_rs[i] && (src[i] != 5'd0);
            exec_hit[i] = active[i] && decode_exec_buff.control.reg_write
                && (decode_exec_buff.control.rd == src[i]);
            mem_hit[i] = active[i] && exec_mem_buff.reg_write
                && (exec_mem_buff.rd == src[i]);

            // Load data is not ready until the memory stage
            load_use[i] = active[i] && decode_exec_buff.control.mem_read
                && (decode_exec_buff.control.rd == src[i]);

            // Youngest producer wins
            if (exec_hit[i]) begin
                bypass_rs[i] = BYPASS_EXEC;
            end else if (mem_hit[i]) begin
                bypass_rs[i] = BYPASS_MEM;
            end else begin
                bypass_rs[i] = BYPASS_NONE;
            end
        end
    end

    assign stall = |load_use;

endmodule

`default_nettype wire

/* hw/rv32_regfile.sv */
// ******************************************************************
// Integer register file, two combinational reads and one write.
// x0 always reads zero. REG_COUNT is 32 for RV32I, 16 for RV32E.
// ******************************************************************
`timescale 1ns/1ps
`default_nettype none

module rv32_regfile #(
    parameter int REG_COUNT = 32
) (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic [4:0]               rs1_addr,
    input  logic [4:0]               rs2_addr,
    output rv32_types_pkg::rv32_word rs1_data,
    output rv32_types_pkg::rv32_word rs2_data,
    input  logic                     wb_en,
    input  logic [4:0]               wb_addr,
    input  rv32_types_pkg::rv32_word wb_data
);
    import rv32_types_pkg::*;

    rv32_word regs [REG_COUNT];

    // Out-of-range indexes read zero as well
    function automatic rv32_word read_reg(logic [4:0] addr);
        if (addr == 5'd0 || int'(addr) >= REG_COUNT) begin
            return '0;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs1_data = read_reg(rs1_addr);
        rs2_data = read_reg(rs2_addr);
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_addr != 5'd0 && int'(wb_addr) < REG_COUNT) begin
            regs[wb_addr] <= wb_data;
        end
    end

endmodule

`default_nettype wire

/* hw/rv32_types_pkg.sv */
// ******************************************************************
// Shared types for the RV32I decode stage and its register file.
// Import into a module body, or use scoped names in port lists.
// ******************************************************************
`default_nettype none

package rv32_types_pkg;

    typedef logic [31:0] rv32_word;
    typedef logic [31:0] rv_instr_t;

    // addi x0, x0, 0
    localparam rv_instr_t RV_NOP = 32'h0000_0013;

    // rs1, rs2 and the CSR value
    localparam int NUM_OPERANDS = 3;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4,
        WB_CSR
    } wb_src_e;

    typedef enum logic [1:0] {
        BYPASS_NONE,
        BYPASS_EXEC,
        BYPASS_MEM
    } bypass_e;

    typedef struct packed {
        alu_op_e       alu_op;
        logic          alu_src_imm;
        rv32_word      imm;
        logic          mem_read;
        logic          mem_write;
        logic          reg_write;
        wb_src_e       wb_result_src;
        logic          branch;
        logic          jump;
        logic          illegal;
        logic [4:0]    rd;
        logic [4:0]    rs1;
        logic [4:0]    rs2;
        bypass_e [1:0] bypass_rs;
    } rv_control_t;

    typedef struct packed {
        rv32_word pc;
        logic     generate_nop;
    } fetch_decode_buffer_t;

    typedef struct packed {
        rv32_word                       pc;
        rv_instr_t                      instr;
        rv_control_t                    control;
        rv32_word [NUM_OPERANDS - 1:0]  reg_data;
    } decode_exec_buffer_t;

    typedef struct packed {
        rv32_word   pc;
        logic [4:0] rd;
        logic       reg_write;
        logic       mem_read;
        rv32_word   alu_result;
    } exec_mem_buffer_t;

    // Control bundle of a bubble, nothing enabled
    function automatic rv_control_t create_nop_ctrl();
        rv_control_t ctrl;
        ctrl = '0;
        ctrl.alu_op = ALU_ADD;
        ctrl.wb_result_src = WB_ALU;
        ctrl.bypass_rs = {BYPASS_NONE, BYPASS_NONE};
        return ctrl;
    endfunction

endpackage

`default_nettype wire

/* sources.f */
hw/rv32_types_pkg.sv
hw/rv32_decoder.sv
hw/rv32_hazard_unit.sv
hw/rv32_decode_stage.sv
hw/rv32_regfile.sv
hw/rv32_decode_top.sv
verif/tb_decode_props.sv
verif/tb_decode_top.sv

/* verif/tb_decode_props.sv */
// **********************************************************************
// Concurrent assertions on the decode stage, bound into every instance.
// **********************************************************************
`timescale 1ns/1ps
`default_nettype none

module tb_decode_props (
    input logic                                clk,
    input logic                                resetn,
    input logic                                stall,
    input logic                                stop,
    input rv32_types_pkg::rv_control_t         dec_control,
    input rv32_types_pkg::bypass_e [1:0]       bypass_rs,
    input rv32_types_pkg::decode_exec_buffer_t decode_exec_buff
);
    import rv32_types_pkg::*;

    // A load-use bubble never writes back
    assert property (@(posedge clk) disable iff (!resetn)
        stall && !stop |=> !decode_exec_buff.control.reg_write)
        else $error("bubble after stall has reg_write set");

    // x0 is never forwarded
    assert property (@(posedge clk) disable iff (!resetn)
        (dec_control.rs1 == 5'd0) |-> (bypass_rs[0] == BYPASS_NONE))
        else $error("bypass selected for rs1 x0");

    assert property (@(posedge clk) disable iff (!resetn)
        (dec_control.rs2 == 5'd0) |-> (bypass_rs[1] == BYPASS_NONE))
        else $error("bypass selected for rs2 x0");

    assert property (@(posedge clk) disable iff (!resetn)
        stop |=> $stable(decode_exec_buff))
        else $error("decode/execute buffer changed under stop");

endmodule

bind rv32_decode_stage tb_decode_props u_props (
    .clk             (clk),
    .resetn          (resetn),
    .stall           (stall),
    .stop            (stop),
    .dec_control     (dec_control),
    .bypass_rs       (bypass_rs),
    .decode_exec_buff(decode_exec_buff)
);

`default_nettype wire

/* verif/tb_decode_top.sv */
// **********************************************************************
// Testbench for rv32_decode_top. Preloads the register file, then runs
// a table of instructions and checks the decode/execute buffer.
// **********************************************************************
`timescale 1ns/1ps
`default_nettype none

module tb_decode_top;
    import rv32_types_pkg::*;

    localparam rv32_word CSR_VAL = 32'hCAFE_0001;
    localparam rv32_word NOP_PC = 32'h0000_0200;
    localparam int NUM_ROWS = 19;

    // Stimulus then expected response per table row
    typedef struct packed {
        rv_instr_t  instr;
        rv32_word   pc;
        logic       gnop;
        logic       snop;
        logic       stop;
        logic [4:0] mem_rd;
        logic       mem_wr;
        logic       wr_first;
        logic       stall;
        alu_op_e    alu;
        rv32_word   imm;
        logic [4:0] rd;
        logic       rw;
        logic       mr;
        wb_src_e    wb;
        logic [3:0] byp;
        logic       ill;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [3:0] en;
    } row_t;

    logic                 clk;
    logic                 resetn;
    rv_instr_t            instr;
    fetch_decode_buffer_t fetch_decode_buff;
    logic                 set_nop;
    rv32_word             set_nop_pc;
    logic                 stop;
    rv32_word             csr_data;
    exec_mem_buffer_t     exec_mem_buff;
    logic                 wb_en;
    logic [4:0]           wb_addr;
    rv32_word             wb_data;
    decode_exec_buffer_t  decode_exec_buff;
    logic                 stall;

    rv32_word shadow [32];
    logic [31:0] lcg_state;
    decode_exec_buffer_t expected;

    // Bypass codes are {rs2, rs1} with 01 for execute and 10 for memory
    // en is {alu_src_imm, mem_write, branch, jump}
    row_t rows [NUM_ROWS] = '{
        '{32'hFFB1_0093, 32'h100, 0, 0, 0, 5'd0, 0, 0, 0, ALU_ADD, 32'hFFFF_FFFB,
          5'd1, 1, 0, WB_ALU, 4'b0000, 0, 5'd2, 5'd0, 4'b1000},
        '{32'h0040_81B3, 32'h104, 0, 0, 0, 5'd4, 1, 0, 0, ALU_ADD, 32'h0,
          5'd3, 1, 0, WB_ALU, 4'b1001, 0, 5'd1, 5'd4, 4'b0000},
        '{32'h4031_82B3, 32'h108, 0, 0, 0, 5'd3, 1, 0, 0, ALU_SUB, 32'h0,
          5'd5, 1, 0, WB_ALU, 4'b0101, 0, 5'd3, 5'd3, 4'b0000},
        '{32'h0082_A303, 32'h10C, 0, 0, 0, 5'd0, 0, 0, 0, ALU_ADD, 32'h8,
          5'd6, 1, 1, WB_MEM, 4'b0001, 0, 5'd5, 5'd0, 4'b1000},
        '{32'h0003_03B3, 32'h110, 0, 0, 0, 5'd0, 0, 0, 1, ALU_ADD, 32'h0,
          5'd0, 0, 0, WB_ALU, 4'b0000, 0, 5'd6, 5'd0, 4'b0000},
        '{32'h0003_03B3, 32'h110, 0, 0, 0, 5'd6, 1, 0, 0, ALU_ADD, 32'h0,
          5'd7, 1, 0, WB_ALU, 4'b0010, 0, 5'd6, 5'd0, 4'b0000},
        '{32'h0070_0433, 32'h114, 0, 0, 0, 5'd0, 1, 0, 0, ALU_ADD, 32'h0,
          5'd8, 1, 0, WB_ALU, 4'b0100, 0, 5'd0, 5'd7, 4'b0000},
        '{32'h1234_54B7, 32'h118, 0, 0, 0, 5'd0, 0, 0, 0, ALU_PASS_B, 32'h1234_5000,
          5'd9, 1, 0, WB_ALU, 4'b0000, 0, 5'd0, 5'd0, 4'b1000},
        '{32'hFFFF_F517, 32'h11C, 0, 0, 0, 5'd0, 0, 0, 0, ALU_ADD, 32'hFFFF_F000,
          5'd10, 1, 0, WB_ALU, 4'b0000, 0, 5'd0, 5'd0, 4'b1000},
        '{32'h0100_00EF, 32'h120, 0, 0, 0, 5'd0, 0, 0, 0, ALU_ADD, 32'h10,
          5'd1, 1, 0, WB_PC4, 4'b0000, 0, 5'd0, 5'd0, 4'b0001},
        '{32'h0040_8067, 32'h124, 0, 0, 0, 5'd0, 0, 0, 0, ALU_ADD, 32'h4,
          5'd0, 1, 0, WB_PC4, 4'b0001, 0, 5'd1, 5'd0, 4'b1001},
        '{32'hFE31_0CE3, 32'h128, 0, 0, 0, 5'd3, 1, 0, 0, ALU_SUB, 32'hFFFF_FFF8,
          5'd0, 0, 0, WB_ALU, 4'b1000, 0, 5'd2, 5'd3, 4'b0010},
        '{32'h0041_2623, 32'h12C, 0, 0, 0, 5'd0, 0, 0, 0, ALU_ADD, 32'hC,
          5'd0, 0, 0, WB_ALU, 4'b0000, 0, 5'd2, 5'd4, 4'b1100},
        '{32'h3000_2573, 32'h130, 0, 0, 0, 5'd0, 0, 0, 0, ALU_OR, 32'h300,
          5'd10, 1, 0, WB_CSR, 4'b0000, 0, 5'd0, 5'd0, 4'b0000},
        '{32'h0000_007F, 32'h134, 0, 0, 0, 5'd0, 0, 0, 0, ALU_ADD, 32'h0,
          5'd0, 0, 0, WB_ALU, 4'b0000, 1, 5'd0, 5'd0, 4'b0000},
        '{32'h0040_81B3, 32'h138, 1, 0, 0, 5'd0, 0, 0, 0, ALU_ADD, 32'h0,
          5'd0, 1, 0, WB_ALU, 4'b0000, 0, 5'd0, 5'd0, 4'b1000},
        '{32'hFFB1_0093, 32'h13C, 0, 1, 0, 5'd0, 0, 0, 0, ALU_ADD, 32'h0,
          5'd0, 0, 0, WB_ALU, 4'b0000, 0, 5'd2, 5'd0, 4'b0000},
        '{32'h1234_54B7, 32'h140, 0, 0, 1, 5'd0, 0, 0, 0, ALU_ADD, 32'h0,
          5'd0, 0, 0, WB_ALU, 4'b0000, 0, 5'd0, 5'd0, 4'b0000},
        '{32'h0001_0633, 32'h144, 0, 0, 0, 5'd0, 0, 1, 0, ALU_ADD, 32'h0,
          5'd12, 1, 0, WB_ALU, 4'b0000, 0, 5'd2, 5'd0, 4'b0000}
    };

    rv32_decode_top #(
        .REG_COUNT(32)
    ) UUT (
        .clk              (clk),
        .resetn           (resetn),
        .instr            (instr),
        .fetch_decode_buff(fetch_decode_buff),
        .set_nop          (set_nop),
        .set_nop_pc       (set_nop_pc),
        .stop             (stop),
        .csr_data         (csr_data),
        .exec_mem_buff    (exec_mem_buff),
        .wb_en            (wb_en),
        .wb_addr          (wb_addr),
        .wb_data          (wb_data),
        .decode_exec_buff (decode_exec_buff),
        .stall            (stall)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Hang guard for the whole run
    initial begin
        #200000;
        $display("Simulation ran past its time limit");
        $display("Test failed");
        $fatal(1, "timeout");
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Control bundle without imm folded into one word
    function automatic logic [31:0] ctrl_bits(rv_control_t c);
        return {c.alu_op, c.rd, c.rs1, c.rs2, c.reg_write, c.mem_read, c.mem_write,
                c.wb_result_src, c.branch, c.jump, c.illegal, c.alu_src_imm,
                4'(c.bypass_rs)};
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
            $display("Test failed");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic compare_output();
        check("decode_exec_buff.pc", decode_exec_buff.pc, expected.pc);
        check("decode_exec_buff.instr", decode_exec_buff.instr, expected.instr);
        check("control.imm", decode_exec_buff.control.imm, expected.control.imm);
        check("control", ctrl_bits(decode_exec_buff.control), ctrl_bits(expected.control));
        check("reg_data[0]", decode_exec_buff.reg_data[0], expected.reg_data[0]);
        check("reg_data[1]", decode_exec_buff.reg_data[1], expected.reg_data[1]);
        check("reg_data[2]", decode_exec_buff.reg_data[2], expected.reg_data[2]);
    endtask

    task automatic write_reg(input logic [4:0] addr, input rv32_word data);
        @(posedge clk);
        wb_en <= 1'b1;
        wb_addr <= addr;
        wb_data <= data;
        @(posedge clk);
        wb_en <= 1'b0;
        if (addr != 5'd0) begin
            shadow[addr] = data;
        end
    endtask

    task automatic apply_row(input row_t r);
        exec_mem_buffer_t emb;
        logic             bubble;
        emb = '0;
        emb.rd = r.mem_rd;
        emb.reg_write = r.mem_wr;
        bubble = r.snop || r.stall;
        @(posedge clk);
        instr <= r.instr;
        fetch_decode_buff.pc <= r.pc;
        fetch_decode_buff.generate_nop <= r.gnop;
        set_nop <= r.snop;
        stop <= r.stop;
        exec_mem_buff <= emb;
        @(negedge clk);
        check("stall", stall, r.stall);
        // Let one capture through, then hold the result
        @(posedge clk);
        stop <= 1'b1;
        // A stopped row keeps the previous result
        if (!r.stop) begin
            expected.pc = r.snop ? NOP_PC : r.pc;
            expected.instr = (r.gnop || bubble) ? RV_NOP : r.instr;
            expected.control.alu_op = r.alu;
            expected.control.alu_src_imm = r.en[3];
            expected.control.imm = r.imm;
            expected.control.mem_read = r.mr;
            expected.control.mem_write = r.en[2];
            expected.control.reg_write = r.rw;
            expected.control.wb_result_src = r.wb;
            expected.control.branch = r.en[1];
            expected.control.jump = r.en[0];
            expected.control.illegal = r.ill;
            expected.control.rd = r.rd;
            expected.control.rs1 = bubble ? 5'd0 : r.rs1;
            expected.control.rs2 = bubble ? 5'd0 : r.rs2;
            expected.control.bypass_rs[0] = bypass_e'(r.byp[1:0]);
            expected.control.bypass_rs[1] = bypass_e'(r.byp[3:2]);
            expected.reg_data[0] = shadow[r.rs1];
            expected.reg_data[1] = shadow[r.rs2];
            expected.reg_data[2] = (r.wb == WB_CSR) ? CSR_VAL : 32'h0;
        end
        @(negedge clk);
        compare_output();
    endtask

    initial begin
        resetn = 1'b0;
        instr = RV_NOP;
        fetch_decode_buff = '0;
        set_nop = 1'b0;
        set_nop_pc = NOP_PC;
        stop = 1'b0;
        csr_data = CSR_VAL;
        exec_mem_buff = '0;
        wb_en = 1'b0;
        wb_addr = 5'd0;
        wb_data = '0;
        lcg_state = 32'h0476_263b;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end

        repeat (5) @(posedge clk);
        resetn <= 1'b1;
        @(negedge clk);
        // Reset value is a NOP with every control field clear
        expected = '0;
        expected.instr = RV_NOP;
        compare_output();
        check("stall", stall, 1'b0);

        @(posedge clk);
        stop <= 1'b1;
        for (int i = 1; i < 32; i++) begin
            write_reg(5'(i), lcg_next());
        end

        for (int i = 0; i < NUM_ROWS; i++) begin
            if (rows[i].wr_first) begin
                write_reg(5'd2, lcg_next());
                write_reg(5'd0, 32'hDEAD_BEEF);
            end
            apply_row(rows[i]);
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire
